//--- tb.f
+incdir+tests
verilog/pipeline_types.sv
verilog/dcache_store.sv
verilog/dcache_ctrl.sv
verilog/data_ram.sv
verilog/cache_soc.sv
tests/cache_soc_tb.sv

//--- tests/cache_ref_model.svh
// memory image of the data RAM and a shadow copy of the cache contents.
logic [31:0]          mem_image    [pipeline_types::RAM_WORDS];
logic                 shadow_valid [pipeline_types::NUM_LINES];
pipeline_types::tag_t shadow_tag   [pipeline_types::NUM_LINES];
logic [31:0]          shadow_line  [pipeline_types::NUM_LINES][pipeline_types::LINE_WORDS];

function automatic void reset_model();
    foreach (mem_image[i]) begin
        mem_image[i] = '0;
    end
    foreach (shadow_valid[i]) begin
        shadow_valid[i] = 1'b0;
    end
endfunction

function automatic logic [31:0] merge_bytes(input logic [31:0] old_word, new_word,
                                            input logic [3:0] strb);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
            merged[b * 8 +: 8] = new_word[b * 8 +: 8];
        end
    end
    return merged;
endfunction

// updates the model for one operation and returns the expected data and latency.
function automatic void predict_op(input logic we, unc, cop, input logic [4:0] code,
                                   input logic [31:0] addr, wdata, input logic [3:0] strb,
                                   output logic [31:0] exp_data, output int exp_lat);
    logic [3:0]  idx;
    logic [22:0] tag;
    logic [2:0]  off;
    logic [9:0]  word;
    logic        hit;
    idx  = addr[8:5];
    tag  = addr[31:9];
    off  = addr[4:2];
    word = addr[11:2];
    hit  = shadow_valid[idx] && (shadow_tag[idx] == tag);
    exp_data = 'x;
    exp_lat  = 2;  // hits, stores and cacops.
    if (cop) begin
        if ((code[2:0] == pipeline_types::CACOP_DCACHE) &&
            (code[4:3] != pipeline_types::CACOP_NONE) &&
            ((code[4:3] != pipeline_types::CACOP_HIT_INV) || hit)) begin
            shadow_valid[idx] = 1'b0;
        end
    end else if (we) begin
        mem_image[word] = merge_bytes(mem_image[word], wdata, strb);
        if (!unc && hit) begin
            shadow_line[idx][off] = merge_bytes(shadow_line[idx][off], wdata, strb);
        end
    end else if (unc) begin
        exp_data = mem_image[word];
        exp_lat  = pipeline_types::RAM_LATENCY + 1;
    end else begin
        if (!hit) begin
            shadow_valid[idx] = 1'b1;
            shadow_tag[idx]   = tag;
            for (int w = 0; w < pipeline_types::LINE_WORDS; w++) begin
                shadow_line[idx][w] = mem_image[{word[9:3], 3'(w)}];
            end
            exp_lat = pipeline_types::RAM_LATENCY + 3;
        end
        exp_data = shadow_line[idx][off];
    end
endfunction

//--- tests/cache_soc_tb.sv
`timescale 1ns/1ps

module cache_soc_tb;

    localparam int NUM_RANDOM      = 300;
    localparam int MAX_OP_CYCLES   = 8;
    localparam int DIRECTED_CYCLES = 1600;   // covers reset and the directed ops with a wide margin.
    localparam int TIMEOUT_CYCLES  = NUM_RANDOM * MAX_OP_CYCLES + DIRECTED_CYCLES;

    logic                   clk;
    logic                   rst_i;
    logic                   req_i;
    logic                   we_i;
    logic                   uncache_i;
    logic                   cacop_i;
    logic [4:0]             cacop_code_i;
    pipeline_types::bus32_t addr_i;
    pipeline_types::bus32_t wdata_i;
    logic [3:0]             wstrb_i;
    logic                   busy_o;
    logic                   ack_o;
    pipeline_types::bus32_t rdata_o;

    int          seed;
    int          cycles = 0;
    int          lat_count;
    bit          counting = 1'b0;
    int          exp_lat_q  [$];
    logic [31:0] exp_data_q [$];
    bit          is_load_q  [$];

    `include "cache_ref_model.svh"

    cache_soc dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual, expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Done: errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // req_i and the registered outputs are settled at the falling edge.
    always @(negedge clk) begin
        if (counting) begin
            lat_count++;
            if (ack_o) begin
                check_value("ack_o latency", lat_count, exp_lat_q[0]);
                check_value("busy_o", busy_o, 32'd0);
                if (is_load_q[0]) begin
                    check_value("rdata_o", rdata_o, exp_data_q[0]);
                end
                void'(exp_lat_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(is_load_q.pop_front());
                counting = 1'b0;
            end else begin
                check_value("busy_o", busy_o, 32'd1);
            end
        end else if (ack_o) begin
            $display("ack_o was seen at %0t while no request was outstanding", $time);
            $display("Done: errors found");
            $fatal(1, "unexpected acknowledge");
        end
        if (req_i) begin
            counting  = 1'b1;
            lat_count = 0;
        end
    end

    task automatic run_op(input logic we, unc, cop, input logic [4:0] code,
                          input logic [31:0] addr, wdata, input logic [3:0] strb);
        logic [31:0] exp_data;
        int          exp_lat;
        while (busy_o) begin
            @(posedge clk);
            #1;
        end
        predict_op(we, unc, cop, code, addr, wdata, strb, exp_data, exp_lat);
        exp_data_q.push_back(exp_data);
        exp_lat_q.push_back(exp_lat);
        is_load_q.push_back(!we && !cop);
        req_i        = 1'b1;
        we_i         = we;
        uncache_i    = unc;
        cacop_i      = cop;
        cacop_code_i = code;
        addr_i       = addr;
        wdata_i      = wdata;
        wstrb_i      = strb;
        @(posedge clk);
        #1;
        req_i = 1'b0;
    endtask

    task automatic load_word(input logic [31:0] addr, input logic unc);
        run_op(1'b0, unc, 1'b0, 5'd0, addr, 32'd0, 4'd0);
    endtask

    task automatic store_word(input logic [31:0] addr, data, input logic [3:0] strb,
                              input logic unc);
        run_op(1'b1, unc, 1'b0, 5'd0, addr, data, strb);
    endtask

    task automatic cache_op(input pipeline_types::cacop_mode_t mode,
                            input pipeline_types::cacop_target_t target,
                            input logic [31:0] addr);
        run_op(1'b0, 1'b0, 1'b1, {mode, target}, addr, 32'd0, 4'd0);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] addr;
        rst_i        = 1'b1;
        req_i        = 1'b0;
        we_i         = 1'b0;
        uncache_i    = 1'b0;
        cacop_i      = 1'b0;
        cacop_code_i = '0;
        addr_i       = '0;
        wdata_i      = '0;
        wstrb_i      = '0;
        seed         = 46235;
        reset_model();
        repeat (2) @(posedge clk);
        #1;
        rst_i = 1'b0;
        check_value("busy_o", busy_o, 32'd0);
        check_value("ack_o", ack_o, 32'd0);

        load_word(32'h100, 1'b0);                      // cold miss.
        store_word(32'h200, 32'h11223344, 4'hf, 1'b0);
        store_word(32'h200, 32'haabbccdd, 4'b0101, 1'b0);
        load_word(32'h200, 1'b0);
        load_word(32'h20c, 1'b0);
        store_word(32'h208, 32'hcafef00d, 4'hf, 1'b0); // store hit.
        load_word(32'h208, 1'b0);

        // uncached accesses do not allocate, and an uncached store leaves a stale line.
        store_word(32'h300, 32'h5a5a1234, 4'hf, 1'b1);
        load_word(32'h300, 1'b1);
        load_word(32'h300, 1'b0);
        store_word(32'h304, 32'h0badbeef, 4'hf, 1'b1);
        load_word(32'h304, 1'b0);
        load_word(32'h304, 1'b1);

        cache_op(pipeline_types::CACOP_INDEX_INV0, pipeline_types::CACOP_DCACHE, 32'h200);
        load_word(32'h200, 1'b0);
        cache_op(pipeline_types::CACOP_INDEX_INV1, pipeline_types::CACOP_DCACHE, 32'h200);
        load_word(32'h200, 1'b0);
        cache_op(pipeline_types::CACOP_HIT_INV, pipeline_types::CACOP_DCACHE, 32'h200);
        load_word(32'h200, 1'b0);
        cache_op(pipeline_types::CACOP_HIT_INV, pipeline_types::CACOP_DCACHE, 32'h000);
        load_word(32'h200, 1'b0);
        cache_op(pipeline_types::CACOP_NONE, pipeline_types::CACOP_DCACHE, 32'h200);
        load_word(32'h200, 1'b0);
        cache_op(pipeline_types::CACOP_INDEX_INV0, pipeline_types::CACOP_ICACHE, 32'h200);
        load_word(32'h200, 1'b0);

        // the random window is 64 words over four tags, two indices and eight offsets.
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r    = $random(seed);
            data = $random(seed);
            addr = {21'd0, r[5:4], 3'd0, r[3], r[2:0], 2'b00};
            case (r[9:7])
                3'd0, 3'd1, 3'd2: load_word(addr, 1'b0);
                3'd3:             load_word(addr, 1'b1);
                3'd4, 3'd5:       store_word(addr, data, r[13:10], 1'b0);
                3'd6:             store_word(addr, data, r[13:10], r[14]);
                default: cache_op(pipeline_types::cacop_mode_t'(r[16:15]),
                                  r[17] ? pipeline_types::CACOP_DCACHE
                                        : pipeline_types::CACOP_ICACHE, addr);
            endcase
        end

        while (busy_o || (exp_lat_q.size() != 0)) begin
            @(posedge clk);
            #1;
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- verilog/cache_soc.sv
`timescale 1ns/1ps

module cache_soc (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    req_i,
    input  logic                    we_i,
    input  logic                    uncache_i,
    input  logic                    cacop_i,
    input  logic [4:0]              cacop_code_i,
    input  pipeline_types::bus32_t  addr_i,
    input  pipeline_types::bus32_t  wdata_i,
    input  logic [3:0]              wstrb_i,
    output logic                    busy_o,
    output logic                    ack_o,
    output pipeline_types::bus32_t  rdata_o
);

    logic dcache_cacop;
    pipeline_types::cacop_mode_t cacop_mode;

    logic st_refill, st_wr, st_inv, st_valid;
    pipeline_types::index_t  st_index;
    pipeline_types::tag_t    st_refill_tag, st_tag;
    pipeline_types::bus256_t st_refill_line, st_line;
    pipeline_types::offset_t st_wr_offset;
    pipeline_types::bus32_t  st_wr_data;
    logic [3:0]              st_wr_strb;

    logic line_req, line_valid, word_req, word_valid, wr_en;
    pipeline_types::bus32_t  line_addr, word_addr, word_data, wr_addr, wr_data;
    pipeline_types::bus256_t line_data;
    logic [3:0]              wr_strb;

    // only a data-cache target reaches the arrays and an icache cacop is just acknowledged.
    assign dcache_cacop = cacop_i && (pipeline_types::cacop_target_t'(cacop_code_i[2:0])
                                      == pipeline_types::CACOP_DCACHE);
    assign cacop_mode = pipeline_types::cacop_mode_t'(cacop_code_i[4:3]);

    dcache_ctrl u_dcache_ctrl (
        .clk, .rst_i, .req_i, .we_i, .uncache_i,
        .cacop_en_i(dcache_cacop), .cacop_any_i(cacop_i), .cacop_mode_i(cacop_mode),
        .addr_i, .wdata_i, .wstrb_i, .busy_o, .ack_o, .rdata_o,
        .st_index_o(st_index), .st_refill_o(st_refill), .st_refill_tag_o(st_refill_tag),
        .st_refill_line_o(st_refill_line), .st_wr_o(st_wr), .st_wr_offset_o(st_wr_offset),
        .st_wr_data_o(st_wr_data), .st_wr_strb_o(st_wr_strb), .st_inv_o(st_inv),
        .st_valid_i(st_valid), .st_tag_i(st_tag), .st_line_i(st_line),
        .line_req_o(line_req), .line_addr_o(line_addr), .line_valid_i(line_valid),
        .line_data_i(line_data), .word_req_o(word_req), .word_addr_o(word_addr),
        .word_valid_i(word_valid), .word_data_i(word_data), .wr_en_o(wr_en),
        .wr_addr_o(wr_addr), .wr_data_o(wr_data), .wr_strb_o(wr_strb)
    );

    dcache_store u_dcache_store (
        .clk, .rst_i, .index_i(st_index),
        .refill_i(st_refill), .refill_tag_i(st_refill_tag), .refill_line_i(st_refill_line),
        .wr_i(st_wr), .wr_offset_i(st_wr_offset), .wr_data_i(st_wr_data),
        .wr_strb_i(st_wr_strb), .inv_i(st_inv),
        .valid_o(st_valid), .tag_o(st_tag), .line_o(st_line)
    );

    data_ram u_data_ram (
        .clk, .rst_i,
        .line_req_i(line_req), .line_addr_i(line_addr),
        .line_valid_o(line_valid), .line_data_o(line_data),
        .word_req_i(word_req), .word_addr_i(word_addr),
        .word_valid_o(word_valid), .word_data_o(word_data),
        .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data), .wr_strb_i(wr_strb)
    );

endmodule

//--- verilog/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     line_req_i,
    input  pipeline_types::bus32_t   line_addr_i,
    output logic                     line_valid_o,
    output pipeline_types::bus256_t  line_data_o,
    input  logic                     word_req_i,
    input  pipeline_types::bus32_t   word_addr_i,
    output logic                     word_valid_o,
    output pipeline_types::bus32_t   word_data_o,
    input  logic                     wr_en_i,
    input  pipeline_types::bus32_t   wr_addr_i,
    input  pipeline_types::bus32_t   wr_data_i,
    input  logic [3:0]               wr_strb_i
);

    localparam int AW  = pipeline_types::RAM_ADDR_BITS;
    localparam int LAT = pipeline_types::RAM_LATENCY;
    localparam int OB  = pipeline_types::OFFSET_BITS;

    pipeline_types::bus32_t mem [pipeline_types::RAM_WORDS] = '{default: '0};

    logic [LAT-1:0] line_pipe;
    logic [LAT-1:0] word_pipe;
    logic [AW-1:0]  line_pipe_addr [LAT];
    logic [AW-1:0]  word_pipe_addr [LAT];
    logic [AW-1:0]  line_base;
    logic [AW-1:0]  wr_index;

    // the word address is byte address bits 11 to 2 and the higher bits are ignored.
    assign line_base = {line_addr_i[AW+1:pipeline_types::OFFSET_LSB+OB], {OB{1'b0}}};
    assign wr_index  = wr_addr_i[AW+1:pipeline_types::OFFSET_LSB];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            line_pipe <= '0;
            word_pipe <= '0;
        end else begin
            line_pipe <= {line_pipe[LAT-2:0], line_req_i};
            word_pipe <= {word_pipe[LAT-2:0], word_req_i};
        end
    end

    always_ff @(posedge clk) begin
        line_pipe_addr[0] <= line_base;
        word_pipe_addr[0] <= word_addr_i[AW+1:pipeline_types::OFFSET_LSB];
        for (int i = 1; i < LAT; i++) begin
            line_pipe_addr[i] <= line_pipe_addr[i-1];
            word_pipe_addr[i] <= word_pipe_addr[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_strb_i[b]) begin
                    mem[wr_index][b * 8 +: 8] <= wr_data_i[b * 8 +: 8];
                end
            end
        end
    end

    // data is read on the valid cycle, so writes made after the request are visible.
    assign line_valid_o = line_pipe[LAT-1];
    assign word_valid_o = word_pipe[LAT-1];
    assign word_data_o  = mem[word_pipe_addr[LAT-1]];

    always_comb begin
        for (int w = 0; w < pipeline_types::LINE_WORDS; w++) begin
            line_data_o[w * 32 +: 32] = mem[line_pipe_addr[LAT-1] + AW'(w)];
        end
    end

    a_one_read_port: assert property (@(posedge clk) disable iff (rst_i)
        !(line_req_i && word_req_i));

endmodule

//--- verilog/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         req_i,
    input  logic                         we_i,
    input  logic                         uncache_i,
    input  logic                         cacop_en_i,
    input  logic                         cacop_any_i,
    input  pipeline_types::cacop_mode_t  cacop_mode_i,
    input  pipeline_types::bus32_t       addr_i,
    input  pipeline_types::bus32_t       wdata_i,
    input  logic [3:0]                   wstrb_i,
    output logic                         busy_o,
    output logic                         ack_o,
    output pipeline_types::bus32_t       rdata_o,
    output pipeline_types::index_t       st_index_o,
    output logic                         st_refill_o,
    output pipeline_types::tag_t         st_refill_tag_o,
    output pipeline_types::bus256_t      st_refill_line_o,
    output logic                         st_wr_o,
    output pipeline_types::offset_t      st_wr_offset_o,
    output pipeline_types::bus32_t       st_wr_data_o,
    output logic [3:0]                   st_wr_strb_o,
    output logic                         st_inv_o,
    input  logic                         st_valid_i,
    input  pipeline_types::tag_t         st_tag_i,
    input  pipeline_types::bus256_t      st_line_i,
    output logic                         line_req_o,
    output pipeline_types::bus32_t       line_addr_o,
    input  logic                         line_valid_i,
    input  pipeline_types::bus256_t      line_data_i,
    output logic                         word_req_o,
    output pipeline_types::bus32_t       word_addr_o,
    input  logic                         word_valid_i,
    input  pipeline_types::bus32_t       word_data_i,
    output logic                         wr_en_o,
    output pipeline_types::bus32_t       wr_addr_o,
    output pipeline_types::bus32_t       wr_data_o,
    output logic [3:0]                   wr_strb_o
);

    pipeline_types::dcache_state_t state;

    pipeline_types::bus32_t      req_addr;
    pipeline_types::bus32_t      req_wdata;
    logic [3:0]                  req_wstrb;
    logic                        req_we;
    logic                        req_uncache;
    logic                        req_cacop_any;
    logic                        req_cacop_en;
    pipeline_types::cacop_mode_t req_mode;

    pipeline_types::tag_t    req_tag;
    pipeline_types::index_t  req_index;
    pipeline_types::offset_t req_offset;
    logic hit;
    logic is_load;
    logic start_uncached;
    logic index_inv;

    assign req_tag    = req_addr[31:pipeline_types::TAG_LSB];
    assign req_index  = req_addr[pipeline_types::TAG_LSB-1:pipeline_types::INDEX_LSB];
    assign req_offset = req_addr[pipeline_types::INDEX_LSB-1:pipeline_types::OFFSET_LSB];

    assign hit     = st_valid_i && (st_tag_i == req_tag);
    assign is_load = !req_we && !req_cacop_any;

    // an uncached load goes to the word port straight from IDLE to meet its latency.
    assign start_uncached = (state == pipeline_types::IDLE) && req_i && uncache_i &&
                            !we_i && !cacop_any_i;

    assign index_inv = (req_mode == pipeline_types::CACOP_INDEX_INV0) ||
                       (req_mode == pipeline_types::CACOP_INDEX_INV1);

    assign busy_o = (state != pipeline_types::IDLE);

    // in IDLE the store reads the incoming index so the tag is ready in LOOKUP.
    assign st_index_o = (state == pipeline_types::IDLE) ?
                        addr_i[pipeline_types::TAG_LSB-1:pipeline_types::INDEX_LSB] : req_index;

    assign st_refill_o      = (state == pipeline_types::REFILL) && line_valid_i;
    assign st_refill_tag_o  = req_tag;
    assign st_refill_line_o = line_data_i;
    assign st_wr_o          = (state == pipeline_types::LOOKUP) && req_we && !req_uncache && hit;
    assign st_wr_offset_o   = req_offset;
    assign st_wr_data_o     = req_wdata;
    assign st_wr_strb_o     = req_wstrb;
    assign st_inv_o = (state == pipeline_types::LOOKUP) && req_cacop_en &&
                      (index_inv || ((req_mode == pipeline_types::CACOP_HIT_INV) && hit));

    assign line_req_o  = (state == pipeline_types::MISS_WAIT);
    assign line_addr_o = {req_addr[31:pipeline_types::INDEX_LSB],
                          {pipeline_types::INDEX_LSB{1'b0}}};
    assign word_req_o  = start_uncached;
    assign word_addr_o = addr_i;

    // stores always write through, hit or not.
    assign wr_en_o   = (state == pipeline_types::LOOKUP) && req_we;
    assign wr_addr_o = req_addr;
    assign wr_data_o = req_wdata;
    assign wr_strb_o = req_wstrb;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= pipeline_types::IDLE;
            ack_o <= 1'b0;
        end else begin
            ack_o <= 1'b0;
            case (state)
                pipeline_types::IDLE: begin
                    if (req_i) begin
                        state <= start_uncached ? pipeline_types::UNCACHED_WAIT
                                                : pipeline_types::LOOKUP;
                    end
                end
                pipeline_types::LOOKUP: begin
                    if (!is_load || hit) begin
                        ack_o <= 1'b1;
                        state <= pipeline_types::IDLE;
                    end else begin
                        state <= pipeline_types::MISS_WAIT;
                    end
                end
                pipeline_types::MISS_WAIT: state <= pipeline_types::REFILL; // line read issued.
                pipeline_types::REFILL: begin
                    if (line_valid_i) begin
                        ack_o <= 1'b1;
                        state <= pipeline_types::IDLE;
                    end
                end
                pipeline_types::UNCACHED_WAIT: begin
                    if (word_valid_i) begin
                        ack_o <= 1'b1;
                        state <= pipeline_types::IDLE;
                    end
                end
                default: state <= pipeline_types::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == pipeline_types::IDLE) && req_i) begin
            req_addr      <= addr_i;
            req_wdata     <= wdata_i;
            req_wstrb     <= wstrb_i;
            req_we        <= we_i && !cacop_any_i;      // a cacop is never a store.
            req_uncache   <= uncache_i && !cacop_any_i;
            req_cacop_any <= cacop_any_i;
            req_cacop_en  <= cacop_en_i;
            req_mode      <= cacop_mode_i;
        end
        if ((state == pipeline_types::LOOKUP) && is_load && hit) begin
            rdata_o <= st_line_i[req_offset * 32 +: 32];
        end else if ((state == pipeline_types::REFILL) && line_valid_i) begin
            rdata_o <= line_data_i[req_offset * 32 +: 32];
        end else if ((state == pipeline_types::UNCACHED_WAIT) && word_valid_i) begin
            rdata_o <= word_data_i;
        end
    end

    a_no_req_when_busy: assert property (@(posedge clk) disable iff (rst_i)
        req_i |-> !busy_o);

    a_ack_single_pulse: assert property (@(posedge clk) disable iff (rst_i)
        ack_o |=> !ack_o);

endmodule

//--- verilog/dcache_store.sv
`timescale 1ns/1ps

module dcache_store (
    input  logic                     clk,
    input  logic                     rst_i,
    input  pipeline_types::index_t   index_i,
    input  logic                     refill_i,
    input  pipeline_types::tag_t     refill_tag_i,
    input  pipeline_types::bus256_t  refill_line_i,
    input  logic                     wr_i,
    input  pipeline_types::offset_t  wr_offset_i,
    input  pipeline_types::bus32_t   wr_data_i,
    input  logic [3:0]               wr_strb_i,
    input  logic                     inv_i,
    output logic                     valid_o,
    output pipeline_types::tag_t     tag_o,
    output pipeline_types::bus256_t  line_o
);

    logic [pipeline_types::NUM_LINES-1:0] valid;
    pipeline_types::tag_t    tag_mem  [pipeline_types::NUM_LINES];
    pipeline_types::bus256_t line_mem [pipeline_types::NUM_LINES];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid   <= '0;
            valid_o <= 1'b0;
        end else begin
            if (refill_i) begin
                valid[index_i] <= 1'b1;
            end else if (inv_i) begin
                valid[index_i] <= 1'b0;
            end
            valid_o <= valid[index_i];  // old value when written in the same cycle.
        end
    end

    always_ff @(posedge clk) begin
        if (refill_i) begin
            tag_mem[index_i]  <= refill_tag_i;
            line_mem[index_i] <= refill_line_i;
        end else if (wr_i) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_strb_i[b]) begin
                    line_mem[index_i][wr_offset_i * 32 + b * 8 +: 8] <= wr_data_i[b * 8 +: 8];
                end
            end
        end
        tag_o  <= tag_mem[index_i];
        line_o <= line_mem[index_i];
    end

    a_refill_xor_write: assert property (@(posedge clk) disable iff (rst_i)
        !(refill_i && wr_i));

endmodule

//--- verilog/pipeline_types.sv
package pipeline_types;

    typedef logic [31:0]  bus32_t;
    typedef logic [255:0] bus256_t;

    // the cache is direct mapped with 8-word lines.
    localparam int LINE_WORDS  = 8;
    localparam int OFFSET_BITS = 3;
    localparam int INDEX_BITS  = 4;
    localparam int TAG_BITS    = 23;
    localparam int OFFSET_LSB  = 2;                        // byte offset below the word select.
    localparam int INDEX_LSB   = OFFSET_LSB + OFFSET_BITS;
    localparam int TAG_LSB     = INDEX_LSB + INDEX_BITS;
    localparam int NUM_LINES   = 2 ** INDEX_BITS;

    localparam int RAM_ADDR_BITS = 10;
    localparam int RAM_WORDS     = 2 ** RAM_ADDR_BITS;
    localparam int RAM_LATENCY   = 3;                      // request cycle to valid cycle.

    typedef logic [INDEX_BITS-1:0]  index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [TAG_BITS-1:0]    tag_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_WAIT,
        REFILL,
        UNCACHED_WAIT
    } dcache_state_t;

    typedef enum logic [2:0] {
        CACOP_ICACHE = 3'd0,
        CACOP_DCACHE = 3'd1
    } cacop_target_t;

    typedef enum logic [1:0] {
        CACOP_INDEX_INV0 = 2'd0,
        CACOP_INDEX_INV1 = 2'd1,
        CACOP_HIT_INV    = 2'd2,
        CACOP_NONE       = 2'd3
    } cacop_mode_t;

endpackage
